//--- design/bertBusPkg.sv
package bertBusPkg;

    //****************************************
    // Bus geometry
    //****************************************
    localparam int AddrWidth = 8;
    localparam int RegionWidth = 2;
    localparam int OffsetWidth = AddrWidth - RegionWidth;

    typedef logic [31:0] regWord_t;

    // Host request, one strobe per access
    typedef struct packed {
        logic wr;
        logic rd;
        logic [AddrWidth-1:0] addr;
        regWord_t wrData;
    } busReq_t;

    // Access as seen by a single register block
    typedef struct packed {
        logic wr;
        logic rd;
        logic [OffsetWidth-1:0] offset;
        regWord_t data;
    } regAccess_t;

    typedef struct packed {
        logic rdValid;
        regWord_t rdData;
    } busRsp_t;

    // Regions from the top address bits, region 3 is unmapped
    localparam logic [RegionWidth-1:0] RegionSys = 2'd0;
    localparam logic [RegionWidth-1:0] RegionPn = 2'd1;
    localparam logic [RegionWidth-1:0] RegionBert = 2'd2;

    // Sys block
    localparam logic [OffsetWidth-1:0] VersionOffset = 6'd0;
    localparam logic [OffsetWidth-1:0] ControlOffset = 6'd1;

    // PN generator
    localparam logic [OffsetWidth-1:0] RateOffset = 6'd0;

    // BERT
    localparam logic [OffsetWidth-1:0] BertCtrlOffset = 6'd0;
    localparam logic [OffsetWidth-1:0] BitCountOffset = 6'd1;
    localparam logic [OffsetWidth-1:0] ErrCountOffset = 6'd2;
    localparam logic [OffsetWidth-1:0] StatusOffset = 6'd3;

    // Low bits of the sys control word
    typedef struct packed {
        logic outSource;
        logic bertSource;
        logic pnEnable;
    } sysControl_t;

endpackage

//--- design/bertStreamPkg.sv
package bertStreamPkg;

    //****************************************
    // Serial stream
    //****************************************

    // One bit per clkEn strobe, in the clk domain
    typedef struct packed {
        logic clkEn;
        logic data;
    } bitStream_t;

    //****************************************
    // PN15 sequence
    //****************************************
    localparam int PnLength = 15;

    // Zero based taps, feedback is their XOR
    localparam int PnTapA = 14;
    localparam int PnTapB = 13;

    // Any nonzero start state works
    localparam logic [PnLength-1:0] PnSeed = 15'h7FFF;

    //****************************************
    // BERT counters
    //****************************************
    localparam int CountWidth = 32;

    //****************************************
    // Stream source codes
    //****************************************

    // Mux input indices, also the register values
    localparam logic SrcPn = 1'b0;
    localparam logic SrcExt = 1'b1;

endpackage

//--- design/sourceMux.sv
`timescale 1ns/1ns

module sourceMux #(
    parameter type payload_t = logic,
    parameter int NumInputs = 2
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic [$clog2(NumInputs)-1:0]         sel,
    input  payload_t [NumInputs-1:0]             in,
    output payload_t                             out
);

    // Registered select, one cycle of latency on every path
    always_ff @(posedge clk) begin
        if (!rstN) begin
            out <= '0;
        end
        else begin
            out <= in[sel];
        end
    end

    // Select must name a real input
    selInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        sel < NumInputs
    );

endmodule

//--- design/busDecode.sv
`timescale 1ns/1ns

module busDecode (
    input  logic                    clk,
    input  logic                    rstN,
    input  bertBusPkg::busReq_t     bus,
    output bertBusPkg::regAccess_t  sysAcc,
    output bertBusPkg::regAccess_t  pnAcc,
    output bertBusPkg::regAccess_t  bertAcc,
    input  bertBusPkg::regWord_t    sysRd,
    input  bertBusPkg::regWord_t    pnRd,
    input  bertBusPkg::regWord_t    bertRd,
    output bertBusPkg::busRsp_t     rsp
);

    localparam int NumRegions = 2 ** bertBusPkg::RegionWidth;

    logic [bertBusPkg::RegionWidth-1:0] region;
    logic [bertBusPkg::RegionWidth-1:0] rdRegionQ;
    logic rdPendQ;
    logic rdValidQ;
    bertBusPkg::regWord_t [NumRegions-1:0] rdWords;
    bertBusPkg::regWord_t rdDataQ;

    function automatic bertBusPkg::regAccess_t gateAccess(
        input bertBusPkg::busReq_t req,
        input logic hit
    );
        bertBusPkg::regAccess_t acc;
        acc.wr = req.wr && hit;
        acc.rd = req.rd && hit;
        acc.offset = req.addr[bertBusPkg::OffsetWidth-1:0];
        acc.data = req.wrData;
        return acc;
    endfunction

    //****************************************
    // Request decode
    //****************************************
    assign region = bus.addr[bertBusPkg::AddrWidth-1 -: bertBusPkg::RegionWidth];

    assign sysAcc = gateAccess(bus, region == bertBusPkg::RegionSys);
    assign pnAcc = gateAccess(bus, region == bertBusPkg::RegionPn);
    assign bertAcc = gateAccess(bus, region == bertBusPkg::RegionBert);

    //****************************************
    // Read-back
    //****************************************

    // Region follows the read while the blocks register their words
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPendQ <= 1'b0;
            rdValidQ <= 1'b0;
            rdRegionQ <= '0;
        end
        else begin
            rdPendQ <= bus.rd;
            rdValidQ <= rdPendQ;
            rdRegionQ <= region;
        end
    end

    assign rdWords[bertBusPkg::RegionSys] = sysRd;
    assign rdWords[bertBusPkg::RegionPn] = pnRd;
    assign rdWords[bertBusPkg::RegionBert] = bertRd;
    assign rdWords[NumRegions-1] = '0;    // unmapped, reads as zero

    sourceMux #(
        .payload_t(bertBusPkg::regWord_t),
        .NumInputs(NumRegions)
    ) rdMux (
        .clk(clk),
        .rstN(rstN),
        .sel(rdRegionQ),
        .in(rdWords),
        .out(rdDataQ)
    );

    assign rsp.rdValid = rdValidQ;
    assign rsp.rdData = rdDataQ;

    // Host issues one kind of access per cycle
    oneAccessKind: assert property (
        @(posedge clk) disable iff (!rstN)
        !(bus.wr && bus.rd)
    );

endmodule

//--- design/bertSysRegs.sv
`timescale 1ns/1ns

module bertSysRegs #(
    parameter bertBusPkg::regWord_t Version = 32'h0001_0000
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  bertBusPkg::regAccess_t  acc,
    output bertBusPkg::regWord_t    rdWord,
    output logic                    pnEnable,
    output logic                    bertSource,
    output logic                    outSource
);

    localparam int CtrlBits = $bits(bertBusPkg::sysControl_t);

    bertBusPkg::sysControl_t ctrlQ;

    //****************************************
    // Control register
    //****************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlQ <= '0;
        end
        else if (acc.wr && acc.offset == bertBusPkg::ControlOffset) begin
            // Undefined upper bits are dropped
            ctrlQ <= bertBusPkg::sysControl_t'(acc.data[CtrlBits-1:0]);
        end
    end

    assign pnEnable = ctrlQ.pnEnable;
    assign bertSource = ctrlQ.bertSource;
    assign outSource = ctrlQ.outSource;

    // Read word held until the next read
    always_ff @(posedge clk) begin
        if (acc.rd) begin
            case (acc.offset)
                bertBusPkg::VersionOffset: begin
                    rdWord <= Version;
                end
                bertBusPkg::ControlOffset: begin
                    rdWord <= {{(32 - CtrlBits){1'b0}}, ctrlQ};
                end
                default: begin
                    rdWord <= '0;
                end
            endcase
        end
    end

endmodule

//--- design/pnGenerator.sv
`timescale 1ns/1ns

module pnGenerator (
    input  logic                        clk,
    input  logic                        rstN,
    input  bertBusPkg::regAccess_t      acc,
    output bertBusPkg::regWord_t        rdWord,
    input  logic                        enable,
    output bertStreamPkg::bitStream_t   pnOut
);

    bertBusPkg::regWord_t rateQ;
    bertBusPkg::regWord_t countQ;
    logic [bertStreamPkg::PnLength-1:0] stateQ;
    logic fire;
    logic feedback;

    //****************************************
    // Rate register and divider
    //****************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rateQ <= '0;
        end
        else if (acc.wr && acc.offset == bertBusPkg::RateOffset) begin
            rateQ <= acc.data;
        end
    end

    // First bit right after enable, then every rate+1 cycles
    assign fire = enable && (countQ == '0);

    always_ff @(posedge clk) begin
        if (!rstN || !enable) begin
            countQ <= '0;
        end
        else if (fire) begin
            countQ <= rateQ;
        end
        else begin
            countQ <= countQ - 1'b1;
        end
    end

    //****************************************
    // PN15 shift register
    //****************************************
    assign feedback = stateQ[bertStreamPkg::PnTapA] ^ stateQ[bertStreamPkg::PnTapB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stateQ <= bertStreamPkg::PnSeed;
            pnOut <= '0;
        end
        else begin
            pnOut.clkEn <= fire;
            if (fire) begin
                stateQ <= {stateQ[bertStreamPkg::PnLength-2:0], feedback};
                pnOut.data <= feedback;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc.rd) begin
            rdWord <= (acc.offset == bertBusPkg::RateOffset) ? rateQ : '0;
        end
    end

    // All zeros would lock the LFSR up for good
    stateNonZero: assert property (
        @(posedge clk) disable iff (!rstN)
        stateQ != '0
    );

endmodule

//--- design/bitErrorTester.sv
`timescale 1ns/1ns

module bitErrorTester #(
    parameter int LockCount = 32
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  bertBusPkg::regAccess_t      acc,
    output bertBusPkg::regWord_t        rdWord,
    input  bertStreamPkg::bitStream_t   rxIn,
    output logic                        locked
);

    localparam int RunWidth = $clog2(LockCount + 1);
    localparam logic [RunWidth-1:0] RunLast = RunWidth'(LockCount - 1);

    logic [bertStreamPkg::PnLength-1:0] localQ;
    logic [RunWidth-1:0] runQ;
    logic lockedQ;
    logic [bertStreamPkg::CountWidth-1:0] bitCountQ;
    logic [bertStreamPkg::CountWidth-1:0] errCountQ;
    logic expected;
    logic mismatch;
    logic clear;

    //****************************************
    // Self-synchronizing checker
    //****************************************

    // Prediction comes from the last 15 received bits
    assign expected = localQ[bertStreamPkg::PnTapA] ^ localQ[bertStreamPkg::PnTapB];
    assign mismatch = rxIn.data != expected;

    assign clear = acc.wr && acc.offset == bertBusPkg::BertCtrlOffset && acc.data[0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            localQ <= '0;
        end
        else if (rxIn.clkEn) begin
            localQ <= {localQ[bertStreamPkg::PnLength-2:0], rxIn.data};
        end
    end

    // Lock and counters, clear wins over a bit in the same cycle
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            runQ <= '0;
            lockedQ <= 1'b0;
            bitCountQ <= '0;
            errCountQ <= '0;
        end
        else if (rxIn.clkEn) begin
            if (lockedQ) begin
                bitCountQ <= bitCountQ + 1'b1;
                if (mismatch) begin
                    errCountQ <= errCountQ + 1'b1;
                end
            end
            else if (mismatch) begin
                runQ <= '0;
            end
            else if (runQ == RunLast) begin
                runQ <= '0;
                lockedQ <= 1'b1;
            end
            else begin
                runQ <= runQ + 1'b1;
            end
        end
    end

    assign locked = lockedQ;

    //****************************************
    // Register read
    //****************************************
    always_ff @(posedge clk) begin
        if (acc.rd) begin
            case (acc.offset)
                bertBusPkg::BitCountOffset: begin
                    rdWord <= bertBusPkg::regWord_t'(bitCountQ);
                end
                bertBusPkg::ErrCountOffset: begin
                    rdWord <= bertBusPkg::regWord_t'(errCountQ);
                end
                bertBusPkg::StatusOffset: begin
                    rdWord <= {31'b0, lockedQ};
                end
                default: begin
                    rdWord <= '0;    // control is write only
                end
            endcase
        end
    end

    // Errors are only counted on counted bits
    errorsBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        errCountQ <= bitCountQ
    );

endmodule

//--- design/bertTop.sv
`timescale 1ns/1ns

module bertTop #(
    parameter bertBusPkg::regWord_t Version = 32'h0001_0000,
    parameter int LockCount = 32
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  bertBusPkg::busReq_t         bus,
    output bertBusPkg::busRsp_t         rsp,
    input  bertStreamPkg::bitStream_t   extIn,
    output bertStreamPkg::bitStream_t   serOut,
    output logic                        bertLock
);

    bertBusPkg::regAccess_t sysAcc;
    bertBusPkg::regAccess_t pnAcc;
    bertBusPkg::regAccess_t bertAcc;
    bertBusPkg::regWord_t sysRd;
    bertBusPkg::regWord_t pnRd;
    bertBusPkg::regWord_t bertRd;
    logic pnEnable;
    logic bertSource;
    logic outSource;
    bertStreamPkg::bitStream_t pnOut;
    bertStreamPkg::bitStream_t bertIn;
    bertStreamPkg::bitStream_t [1:0] streams;

    //****************************************
    // Register bus
    //****************************************
    busDecode decode (
        .clk(clk),
        .rstN(rstN),
        .bus(bus),
        .sysAcc(sysAcc),
        .pnAcc(pnAcc),
        .bertAcc(bertAcc),
        .sysRd(sysRd),
        .pnRd(pnRd),
        .bertRd(bertRd),
        .rsp(rsp)
    );

    bertSysRegs #(.Version(Version)) sysRegs (
        .clk(clk),
        .rstN(rstN),
        .acc(sysAcc),
        .rdWord(sysRd),
        .pnEnable(pnEnable),
        .bertSource(bertSource),
        .outSource(outSource)
    );

    //****************************************
    // Stream path
    //****************************************
    pnGenerator pnGen (
        .clk(clk),
        .rstN(rstN),
        .acc(pnAcc),
        .rdWord(pnRd),
        .enable(pnEnable),
        .pnOut(pnOut)
    );

    // Both muxes choose from the same two sources
    assign streams[bertStreamPkg::SrcPn] = pnOut;
    assign streams[bertStreamPkg::SrcExt] = extIn;

    sourceMux #(
        .payload_t(bertStreamPkg::bitStream_t),
        .NumInputs(2)
    ) bertSourceMux (
        .clk(clk),
        .rstN(rstN),
        .sel(bertSource),
        .in(streams),
        .out(bertIn)
    );

    sourceMux #(
        .payload_t(bertStreamPkg::bitStream_t),
        .NumInputs(2)
    ) serOutMux (
        .clk(clk),
        .rstN(rstN),
        .sel(outSource),
        .in(streams),
        .out(serOut)
    );

    bitErrorTester #(.LockCount(LockCount)) bert (
        .clk(clk),
        .rstN(rstN),
        .acc(bertAcc),
        .rdWord(bertRd),
        .rxIn(bertIn),
        .locked(bertLock)
    );

endmodule

//--- test/bertModel.svh
`ifndef BERT_MODEL_SVH
`define BERT_MODEL_SVH

//****************************************
// PN15 reference
//****************************************

// Next PN bit is the XOR of the two taps
function automatic logic pnBit(input logic [bertStreamPkg::PnLength-1:0] state);
    return state[bertStreamPkg::PnTapA] ^ state[bertStreamPkg::PnTapB];
endfunction

function automatic logic [bertStreamPkg::PnLength-1:0] pnStep(
    input logic [bertStreamPkg::PnLength-1:0] state
);
    return {state[bertStreamPkg::PnLength-2:0], pnBit(state)};
endfunction

//****************************************
// Checker reference
//****************************************
typedef struct packed {
    logic [bertStreamPkg::PnLength-1:0] shiftReg;
    logic [31:0] run;
    logic locked;
    logic [bertStreamPkg::CountWidth-1:0] bitCount;
    logic [bertStreamPkg::CountWidth-1:0] errCount;
} checkerModel_t;

// One received bit
function automatic checkerModel_t checkerStep(
    input checkerModel_t s,
    input logic rxBit,
    input int lockCount
);
    checkerModel_t n;
    logic miss;
    n = s;
    miss = rxBit != pnBit(s.shiftReg);
    n.shiftReg = {s.shiftReg[bertStreamPkg::PnLength-2:0], rxBit};
    if (s.locked) begin
        n.bitCount = s.bitCount + 1;
        if (miss) begin
            n.errCount = s.errCount + 1;
        end
    end
    else if (miss) begin
        n.run = '0;
    end
    else begin
        n.run = s.run + 1;
        if (n.run == lockCount) begin
            n.locked = 1'b1;
        end
    end
    return n;
endfunction

// Clear keeps the received history
function automatic checkerModel_t checkerClear(input checkerModel_t s);
    checkerModel_t n;
    n = s;
    n.run = '0;
    n.locked = 1'b0;
    n.bitCount = '0;
    n.errCount = '0;
    return n;
endfunction

//****************************************
// Register defaults
//****************************************
function automatic bertBusPkg::regWord_t regDefault(
    input logic [1:0] region,
    input logic [5:0] offset,
    input bertBusPkg::regWord_t version
);
    if (region == bertBusPkg::RegionSys && offset == bertBusPkg::VersionOffset) begin
        return version;
    end
    // Control, rate, counters and status start at zero
    return '0;
endfunction

`endif

//--- test/bertTopTb.sv
`timescale 1ns/1ns

module bertTopTb;

    localparam bertBusPkg::regWord_t Version = 32'h00B3_0102;
    localparam int LockCount = 32;
    localparam int Timeout = 2000;
    localparam logic [1:0] RegionNone = 2'd3;

    `include "bertModel.svh"

    logic clk;
    logic rstN;
    bertBusPkg::busReq_t bus;
    bertBusPkg::busRsp_t rsp;
    bertStreamPkg::bitStream_t extIn;
    bertStreamPkg::bitStream_t serOut;
    logic bertLock;

    int seed = 17;
    int errors = 0;
    int checks = 0;
    int testErrors = 0;

    // Stream monitor state
    logic pnWatch = 1'b0;
    logic extWatch = 1'b0;
    logic [bertStreamPkg::PnLength-1:0] pnState = bertStreamPkg::PnSeed;
    int cycle = 0;
    int lastStrobe = -1;
    int spacing = 1;
    int pnBits = 0;
    int preLockBits = 0;
    int lockedBits = 0;
    logic expOut[$];
    checkerModel_t model;

    bertTop #(
        .Version(Version),
        .LockCount(LockCount)
    ) dut (
        .clk(clk),
        .rstN(rstN),
        .bus(bus),
        .rsp(rsp),
        .extIn(extIn),
        .serOut(serOut),
        .bertLock(bertLock)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //****************************************
    // Checks and bus tasks
    //****************************************
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic endTest(input string name);
        if (errors == testErrors) begin
            $display("%s: passed", name);
        end
        else begin
            $display("%s: %0d failures", name, errors - testErrors);
        end
        testErrors = errors;
    endtask

    function automatic bertBusPkg::regWord_t controlWord(input logic pnEn,
                                                         input logic bertSrc,
                                                         input logic outSrc);
        return {29'b0, outSrc, bertSrc, pnEn};
    endfunction

    task automatic busWrite(input logic [1:0] region, input logic [5:0] offset,
                            input bertBusPkg::regWord_t data);
        @(posedge clk);
        bus <= '{wr: 1'b1, rd: 1'b0, addr: {region, offset}, wrData: data};
        @(posedge clk);
        bus <= '0;
    endtask

    // Latency counted from the edge that takes the strobe
    task automatic busRead(input logic [1:0] region, input logic [5:0] offset,
                           output bertBusPkg::regWord_t data);
        int waited;
        @(posedge clk);
        bus <= '{wr: 1'b0, rd: 1'b1, addr: {region, offset}, wrData: '0};
        @(posedge clk);
        bus <= '0;
        waited = 1;
        @(negedge clk);
        while (!rsp.rdValid && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        data = rsp.rdData;
        if (!rsp.rdValid) begin
            reportFailure($sformatf("Read of region %0d offset %0d never got rdValid",
                                    region, offset));
        end
        else begin
            checkValue("rdValid latency", waited, 2);
        end
    endtask

    task automatic checkRead(input string name, input logic [1:0] region,
                             input logic [5:0] offset, input bertBusPkg::regWord_t expected);
        bertBusPkg::regWord_t data;
        busRead(region, offset, data);
        checkValue(name, data, expected);
    endtask

    task automatic driveExtBit(input logic b, input int gap);
        @(posedge clk);
        extIn <= '{clkEn: 1'b1, data: b};
        if (extWatch) begin
            expOut.push_back(b);
        end
        model = checkerStep(model, b, LockCount);
        @(posedge clk);
        extIn <= '0;
        repeat (gap) @(posedge clk);
    endtask

    //****************************************
    // Stream monitor
    //****************************************
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (serOut.clkEn) begin
            // serOut has the BERT input's timing so bertLock matches its count here
            if (bertLock) begin
                lockedBits = lockedBits + 1;
            end
            else begin
                preLockBits = preLockBits + 1;
            end
            if (!pnWatch && !extWatch) begin
                reportFailure("serOut strobe arrived while no source was running");
            end
            if (pnWatch) begin
                checkValue("serOut.data", 32'(serOut.data), 32'(pnBit(pnState)));
                pnState = pnStep(pnState);
                pnBits = pnBits + 1;
                if (lastStrobe >= 0) begin
                    checkValue("serOut.clkEn spacing", cycle - lastStrobe, spacing);
                end
                lastStrobe = cycle;
            end
            if (extWatch) begin
                if (expOut.size() == 0) begin
                    reportFailure("serOut strobe arrived with no extIn bit pending");
                end
                else begin
                    checkValue("serOut.data", 32'(serOut.data), 32'(expOut.pop_front()));
                end
            end
        end
    end

    //****************************************
    // Tests
    //****************************************
    initial begin
        bertBusPkg::regWord_t wdata;
        logic [bertStreamPkg::PnLength-1:0] extPn;
        logic b;
        int rate;
        int extra;
        int waited;
        int base;
        int preBase;

        bus = '0;
        extIn = '0;
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        // Register read-back
        checkRead("version", bertBusPkg::RegionSys, bertBusPkg::VersionOffset,
                  regDefault(bertBusPkg::RegionSys, bertBusPkg::VersionOffset, Version));
        checkRead("control", bertBusPkg::RegionSys, bertBusPkg::ControlOffset,
                  regDefault(bertBusPkg::RegionSys, bertBusPkg::ControlOffset, Version));
        checkRead("rate", bertBusPkg::RegionPn, bertBusPkg::RateOffset,
                  regDefault(bertBusPkg::RegionPn, bertBusPkg::RateOffset, Version));
        checkRead("status", bertBusPkg::RegionBert, bertBusPkg::StatusOffset,
                  regDefault(bertBusPkg::RegionBert, bertBusPkg::StatusOffset, Version));
        // Generator stays off so the PN model keeps its seed
        wdata = $random(seed) & ~32'h1;
        busWrite(bertBusPkg::RegionSys, bertBusPkg::ControlOffset, wdata);
        checkRead("control", bertBusPkg::RegionSys, bertBusPkg::ControlOffset, wdata & 32'h7);
        wdata = $random(seed);
        busWrite(bertBusPkg::RegionPn, bertBusPkg::RateOffset, wdata);
        checkRead("rate", bertBusPkg::RegionPn, bertBusPkg::RateOffset, wdata);
        checkRead("unmapped", RegionNone, 6'($random(seed)), '0);
        endTest("register read-back");

        // PN stream on serOut
        rate = $random(seed) & 7;
        spacing = rate + 1;
        pnWatch = 1'b1;
        busWrite(bertBusPkg::RegionPn, bertBusPkg::RateOffset, rate);
        busWrite(bertBusPkg::RegionSys, bertBusPkg::ControlOffset,
                 controlWord(1'b1, bertStreamPkg::SrcPn, bertStreamPkg::SrcPn));
        base = pnBits;
        waited = 0;
        while (pnBits - base < 48 && waited < Timeout) begin
            @(posedge clk);
            waited++;
        end
        if (pnBits - base < 48) begin
            reportFailure("PN stream stopped before 48 bits");
        end
        endTest("PN stream");

        // Clean lock on the generator with the history already in sync
        busWrite(bertBusPkg::RegionBert, bertBusPkg::BertCtrlOffset, 32'h1);
        preBase = preLockBits;
        base = lockedBits;
        waited = 0;
        @(negedge clk);
        while (!bertLock && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!bertLock) begin
            reportFailure("bertLock never rose on the PN stream");
        end
        checkValue("bits to lock", preLockBits - preBase, LockCount);
        extra = 5 + ($random(seed) & 31);
        waited = 0;
        while (lockedBits - base < extra && waited < Timeout) begin
            @(posedge clk);
            waited++;
        end
        if (lockedBits - base < extra) begin
            reportFailure("PN stream stopped before the extra locked bits");
        end
        busWrite(bertBusPkg::RegionSys, bertBusPkg::ControlOffset,
                 controlWord(1'b0, bertStreamPkg::SrcPn, bertStreamPkg::SrcPn));
        repeat (6) @(posedge clk);
        checkRead("bitCount", bertBusPkg::RegionBert, bertBusPkg::BitCountOffset,
                  lockedBits - base);
        checkRead("errCount", bertBusPkg::RegionBert, bertBusPkg::ErrCountOffset, '0);
        checkRead("status", bertBusPkg::RegionBert, bertBusPkg::StatusOffset, 32'h1);
        endTest("clean lock");

        // Error counting on extIn
        pnWatch = 1'b0;
        busWrite(bertBusPkg::RegionSys, bertBusPkg::ControlOffset,
                 controlWord(1'b0, bertStreamPkg::SrcExt, bertStreamPkg::SrcPn));
        busWrite(bertBusPkg::RegionBert, bertBusPkg::BertCtrlOffset, 32'h1);
        // Checker history is the last 15 generator bits
        model = '{shiftReg: pnState, run: '0, locked: 1'b0, bitCount: '0, errCount: '0};
        extPn = bertStreamPkg::PnSeed;
        for (int i = 0; i < 200; i++) begin
            b = pnBit(extPn);
            extPn = pnStep(extPn);
            if (model.locked && ($random(seed) & 7) == 0) begin
                b = ~b;
            end
            driveExtBit(b, $random(seed) & 3);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkValue("bertLock", 32'(bertLock), 32'(model.locked));
        checkRead("bitCount", bertBusPkg::RegionBert, bertBusPkg::BitCountOffset,
                  model.bitCount);
        checkRead("errCount", bertBusPkg::RegionBert, bertBusPkg::ErrCountOffset,
                  model.errCount);
        endTest("error counting");

        // Clear and loop-out of extIn
        extWatch = 1'b1;
        busWrite(bertBusPkg::RegionSys, bertBusPkg::ControlOffset,
                 controlWord(1'b0, bertStreamPkg::SrcExt, bertStreamPkg::SrcExt));
        // Flush injected errors out of the checker history
        for (int i = 0; i < 16; i++) begin
            driveExtBit(pnBit(extPn), $random(seed) & 3);
            extPn = pnStep(extPn);
        end
        busWrite(bertBusPkg::RegionBert, bertBusPkg::BertCtrlOffset, 32'h1);
        model = checkerClear(model);
        preBase = preLockBits;
        @(negedge clk);
        checkValue("bertLock", 32'(bertLock), 32'h0);
        checkRead("bitCount", bertBusPkg::RegionBert, bertBusPkg::BitCountOffset, '0);
        checkRead("errCount", bertBusPkg::RegionBert, bertBusPkg::ErrCountOffset, '0);
        for (int i = 0; i < LockCount - 1; i++) begin
            driveExtBit(pnBit(extPn), $random(seed) & 3);
            extPn = pnStep(extPn);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkValue("bertLock", 32'(bertLock), 32'(model.locked));
        driveExtBit(pnBit(extPn), 0);
        extPn = pnStep(extPn);
        waited = 0;
        @(negedge clk);
        while (!bertLock && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!bertLock) begin
            reportFailure("bertLock did not return after the clear");
        end
        checkValue("bits to lock", preLockBits - preBase, LockCount);
        waited = 0;
        while (expOut.size() != 0 && waited < Timeout) begin
            @(posedge clk);
            waited++;
        end
        if (expOut.size() != 0) begin
            reportFailure("extIn bits never appeared on serOut");
        end
        endTest("clear and loop-out");

        $display("Tests: 5  checks: %0d  failures: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- bitsyncBert.f
+incdir+test
design/bertBusPkg.sv
design/bertStreamPkg.sv
design/sourceMux.sv
design/busDecode.sv
design/bertSysRegs.sv
design/pnGenerator.sv
design/bitErrorTester.sv
design/bertTop.sv
test/bertTopTb.sv

//--- Makefile
SIM = obj_dir/bertSim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f bitsyncBert.f --top-module bertTopTb -o bertSim

run: compile
	-$(SIM) > sim.log 2>&1
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
